//--- source/lpif_pkg.sv
// Flit layout and PHY word framing shared by the LPIF link RTL and testbench.
// Import with lpif_pkg::* inside a module body.
package lpif_pkg;

  ////////////////////
  // Geometry
  ////////////////////

  // One 80-bit AIB-style PHY word per lane
  localparam int phy_width = 80;

  // Strobe in the LSB, marker in the MSB
  localparam int phy_strobe_bit = 0;
  localparam int phy_marker_bit = 79;

  // Payload sits between strobe and marker
  localparam int lane_payload_width = phy_width - 2;

  // Full LPIF flit
  localparam int flit_width = 145;

  // Remainder of the flit rides on phy1
  localparam int lane_hi_width = flit_width - lane_payload_width;

  ////////////////////
  // Flit views
  ////////////////////

  // LPIF field order on the wire, MSB first
  typedef struct packed {
    logic [3:0]   state;
    logic [1:0]   protid;
    logic [127:0] data;
    logic         dvalid;
    logic [7:0]   crc;
    logic         crc_valid;
    logic         valid;
  } lpif_flit_t;

  // Same bits cut into the two lane slices
  typedef struct packed {
    logic [lane_hi_width-1:0]      hi;
    logic [lane_payload_width-1:0] lo;
  } flit_lanes_t;

  // Map side uses fields, PHY side uses lanes
  typedef union packed {
    lpif_flit_t  fields;
    flit_lanes_t lanes;
  } lpif_flit_u;

  // Debug status word for both directions
  typedef logic [31:0] dbg_status_t;

endpackage

//--- source/ll_auto_sync.sv
// Online hold-off for both link directions, plus strobe and marker user bits.
// Instantiated once in the link top level.
`timescale 1ns/1ps

module ll_auto_sync #(
  parameter bit PERSISTENT_STROBE = 1'b1,
  parameter bit PERSISTENT_MARKER = 1'b1
) (
  input  logic        clk_wr,
  input  logic        rst_n,
  input  logic        tx_online,
  input  logic        rx_online,
  input  logic [15:0] delay_x_value,
  input  logic [15:0] delay_y_value,
  input  logic        tx_mrk_userbit,
  input  logic        tx_stb_userbit,
  output logic        tx_online_dly,
  output logic        rx_online_dly,
  output logic        auto_mrk,
  output logic        auto_stb
);

  ////////////////////
  // Per-direction state
  ////////////////////

  // Index 0 is transmit, index 1 is receive
  logic [1:0]  online_in;
  logic [15:0] delay_val [2];
  logic [15:0] hold_cnt  [2];
  logic [1:0]  online_dly;

  assign online_in    = {rx_online, tx_online};
  assign delay_val[0] = delay_x_value;
  assign delay_val[1] = delay_y_value;

  ////////////////////
  // Hold-off counters
  ////////////////////

  // Counter tracks consecutive high samples of the online input.
  // Flag rises on the sample after delay+1 highs have been seen,
  // drops on the first low sample.
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      for (int i = 0; i < 2; i++) begin
        hold_cnt[i]   <= '0;
        online_dly[i] <= 1'b0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (!online_in[i]) begin
          // Dropped online restarts the hold-off
          hold_cnt[i]   <= '0;
          online_dly[i] <= 1'b0;
        end else if (hold_cnt[i] > delay_val[i]) begin
          online_dly[i] <= 1'b1;
        end else if (hold_cnt[i] != 16'hffff) begin
          // Stops at delay+1, never wraps
          hold_cnt[i] <= hold_cnt[i] + 16'd1;
        end
      end
    end
  end

  assign tx_online_dly = online_dly[0];
  assign rx_online_dly = online_dly[1];

  ////////////////////
  // Framing user bits
  ////////////////////

  // Forced high, or straight from the user bit
  assign auto_stb = PERSISTENT_STROBE ? 1'b1 : tx_stb_userbit;
  assign auto_mrk = PERSISTENT_MARKER ? 1'b1 : tx_mrk_userbit;

endmodule

//--- source/lpif_flit_map.sv
// Maps user-side LPIF fields to and from the fields view of the flit.
// Only place where the on-wire field order is fixed.
`timescale 1ns/1ps

module lpif_flit_map (
  // Downstream LPIF fields
  input  logic [3:0]          dstrm_state,
  input  logic [1:0]          dstrm_protid,
  input  logic [127:0]        dstrm_data,
  input  logic                dstrm_dvalid,
  input  logic [7:0]          dstrm_crc,
  input  logic                dstrm_crc_valid,
  input  logic                dstrm_valid,
  // Flits to and from the PHY side
  input  lpif_pkg::lpif_flit_u rx_flit,
  output lpif_pkg::lpif_flit_u tx_flit,
  // Upstream LPIF fields
  output logic [3:0]          ustrm_state,
  output logic [1:0]          ustrm_protid,
  output logic [127:0]        ustrm_data,
  output logic                ustrm_dvalid,
  output logic [7:0]          ustrm_crc,
  output logic                ustrm_crc_valid,
  output logic                ustrm_valid
);

  // Downstream pack, purely combinational
  always_comb begin
    tx_flit.fields.state     = dstrm_state;
    tx_flit.fields.protid    = dstrm_protid;
    tx_flit.fields.data      = dstrm_data;
    tx_flit.fields.dvalid    = dstrm_dvalid;
    tx_flit.fields.crc       = dstrm_crc;
    tx_flit.fields.crc_valid = dstrm_crc_valid;
    tx_flit.fields.valid     = dstrm_valid;
  end

  // Upstream unpack, zero flit gives zero fields
  assign ustrm_state     = rx_flit.fields.state;
  assign ustrm_protid    = rx_flit.fields.protid;
  assign ustrm_data      = rx_flit.fields.data;
  assign ustrm_dvalid    = rx_flit.fields.dvalid;
  assign ustrm_crc       = rx_flit.fields.crc;
  assign ustrm_crc_valid = rx_flit.fields.crc_valid;
  assign ustrm_valid     = rx_flit.fields.valid;

endmodule

//--- source/lpif_phy_concat.sv
// Splits flits onto the phy0/phy1 lanes with strobe and marker framing, and
// rebuilds received flits after the strobe check. Also keeps link counters.
`timescale 1ns/1ps

module lpif_phy_concat (
  input  logic                  clk_wr,
  input  logic                  rst_n,
  input  lpif_pkg::lpif_flit_u  tx_flit,
  input  logic                  tx_online_dly,
  input  logic                  rx_online_dly,
  input  logic                  auto_stb,
  input  logic                  auto_mrk,
  input  logic [79:0]           rx_phy0,
  input  logic [79:0]           rx_phy1,
  output lpif_pkg::lpif_flit_u  rx_flit,
  output logic [79:0]           tx_phy0,
  output logic [79:0]           tx_phy1,
  output lpif_pkg::dbg_status_t tx_debug,
  output lpif_pkg::dbg_status_t rx_debug
);

  import lpif_pkg::*;

  logic [phy_width-1:0]  tx_word0;
  logic [phy_width-1:0]  tx_word1;
  logic [flit_width-1:0] rx_bits;
  logic                  rx_stb;
  logic [17:0]           sent_cnt;
  logic [17:0]           acc_cnt;
  logic [11:0]           err_cnt;

  ////////////////////
  // Transmit framing
  ////////////////////

  // Strobe and marker on both lanes, payload in between
  always_comb begin
    tx_word0 = '0;
    tx_word0[phy_strobe_bit] = auto_stb;
    tx_word0[phy_marker_bit] = auto_mrk;
    tx_word0[phy_strobe_bit+1 +: lane_payload_width] = tx_flit.lanes.lo;
    // phy1 payload above hi slice stays zero
    tx_word1 = '0;
    tx_word1[phy_strobe_bit] = auto_stb;
    tx_word1[phy_marker_bit] = auto_mrk;
    tx_word1[phy_strobe_bit+1 +: lane_hi_width] = tx_flit.lanes.hi;
  end

  // One-cycle lane register, lanes idle at zero while offline
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else if (tx_online_dly) begin
      tx_phy0 <= tx_word0;
      tx_phy1 <= tx_word1;
    end else begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end
  end

  ////////////////////
  // Receive path
  ////////////////////

  // Only phy0 strobe gates acceptance
  assign rx_stb  = rx_phy0[phy_strobe_bit];
  assign rx_bits = {rx_phy1[phy_strobe_bit+1 +: lane_hi_width],
                    rx_phy0[phy_strobe_bit+1 +: lane_payload_width]};

  // Dropped words show up as an all-zero flit
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      rx_flit <= '0;
    end else if (rx_online_dly && rx_stb) begin
      rx_flit <= rx_bits;
    end else begin
      rx_flit <= '0;
    end
  end

  ////////////////////
  // Link counters
  ////////////////////

  // All counters saturate at full scale
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      sent_cnt <= '0;
      acc_cnt  <= '0;
      err_cnt  <= '0;
    end else begin
      // Words leaving on the lanes
      if (tx_online_dly && (sent_cnt != '1)) sent_cnt <= sent_cnt + 18'd1;
      // Words accepted with good strobe
      if (rx_online_dly && rx_stb && (acc_cnt != '1)) acc_cnt <= acc_cnt + 18'd1;
      // Online but strobe missing
      if (rx_online_dly && !rx_stb && (err_cnt != '1)) err_cnt <= err_cnt + 12'd1;
    end
  end

  // Status words: error count or zero, both online flags, then word count
  assign tx_debug = {12'h000, tx_online_dly, rx_online_dly, sent_cnt};
  assign rx_debug = {err_cnt, tx_online_dly, rx_online_dly, acc_cnt};

endmodule

//--- source/lpif_link_master_top.sv
// Master side of the LPIF link over two AIB-style lanes in the clk_wr domain.
// Ties auto-sync, flit mapping and lane concatenation together.
`timescale 1ns/1ps

module lpif_link_master_top #(
  parameter bit PERSISTENT_STROBE = 1'b1,
  parameter bit PERSISTENT_MARKER = 1'b1
) (
  input  logic                  clk_wr,
  input  logic                  rst_n,
  // Link control and static settings
  input  logic                  tx_online,
  input  logic                  rx_online,
  input  logic [15:0]           delay_x_value,
  input  logic [15:0]           delay_y_value,
  input  logic                  tx_mrk_userbit,
  input  logic                  tx_stb_userbit,
  // PHY lanes
  output logic [79:0]           tx_phy0,
  input  logic [79:0]           rx_phy0,
  output logic [79:0]           tx_phy1,
  input  logic [79:0]           rx_phy1,
  // Downstream LPIF
  input  logic [3:0]            dstrm_state,
  input  logic [1:0]            dstrm_protid,
  input  logic [127:0]          dstrm_data,
  input  logic                  dstrm_dvalid,
  input  logic [7:0]            dstrm_crc,
  input  logic                  dstrm_crc_valid,
  input  logic                  dstrm_valid,
  // Upstream LPIF
  output logic [3:0]            ustrm_state,
  output logic [1:0]            ustrm_protid,
  output logic [127:0]          ustrm_data,
  output logic                  ustrm_dvalid,
  output logic [7:0]            ustrm_crc,
  output logic                  ustrm_crc_valid,
  output logic                  ustrm_valid,
  // Debug status
  output lpif_pkg::dbg_status_t tx_downstream_debug_status,
  output lpif_pkg::dbg_status_t rx_upstream_debug_status
);

  import lpif_pkg::*;

  lpif_flit_u tx_flit;
  lpif_flit_u rx_flit;
  logic       tx_online_dly;
  logic       rx_online_dly;
  logic       auto_stb;
  logic       auto_mrk;

  ////////////////////
  // Online hold-off
  ////////////////////

  ll_auto_sync #(
    .PERSISTENT_STROBE (PERSISTENT_STROBE),
    .PERSISTENT_MARKER (PERSISTENT_MARKER)
  ) u_auto_sync (
    .clk_wr         (clk_wr),
    .rst_n          (rst_n),
    .tx_online      (tx_online),
    .rx_online      (rx_online),
    .delay_x_value  (delay_x_value),
    .delay_y_value  (delay_y_value),
    .tx_mrk_userbit (tx_mrk_userbit),
    .tx_stb_userbit (tx_stb_userbit),
    .tx_online_dly  (tx_online_dly),
    .rx_online_dly  (rx_online_dly),
    .auto_mrk       (auto_mrk),
    .auto_stb       (auto_stb)
  );

  ////////////////////
  // Field mapping
  ////////////////////

  lpif_flit_map u_flit_map (
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .rx_flit         (rx_flit),
    .tx_flit         (tx_flit),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid)
  );

  ////////////////////
  // Lane concat
  ////////////////////

  // Upstream fields trail loopback input by two cycles
  lpif_phy_concat u_phy_concat (
    .clk_wr        (clk_wr),
    .rst_n         (rst_n),
    .tx_flit       (tx_flit),
    .tx_online_dly (tx_online_dly),
    .rx_online_dly (rx_online_dly),
    .auto_stb      (auto_stb),
    .auto_mrk      (auto_mrk),
    .rx_phy0       (rx_phy0),
    .rx_phy1       (rx_phy1),
    .rx_flit       (rx_flit),
    .tx_phy0       (tx_phy0),
    .tx_phy1       (tx_phy1),
    .tx_debug      (tx_downstream_debug_status),
    .rx_debug      (rx_upstream_debug_status)
  );

endmodule

//--- tests/tb_clock_gen.sv
// Clock and reset source for the LPIF link testbench.
// Reset is released a short delay after the last reset edge.
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int period_ns    = 40,
  parameter int reset_cycles = 8
) (
  output logic clk_wr,
  output logic rst_n
);

  // Free-running clk_wr
  initial begin
    clk_wr = 1'b0;
    forever #(period_ns / 2) clk_wr = ~clk_wr;
  end

  // Synchronous reset held low for the first edges
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk_wr);
    #2;
    rst_n = 1'b1;
  end

endmodule

//--- tests/lpif_link_assert.sv
// Concurrent checks on lane framing and reset values of the lane concat block.
// Bound into every lpif_phy_concat instance.
`timescale 1ns/1ps

module lpif_link_assert (
  input logic                  clk_wr,
  input logic                  rst_n,
  input logic                  tx_online_dly,
  input logic                  auto_stb,
  input logic                  auto_mrk,
  input logic [79:0]           tx_phy0,
  input logic [79:0]           tx_phy1,
  input lpif_pkg::lpif_flit_u  rx_flit,
  input lpif_pkg::dbg_status_t tx_debug,
  input lpif_pkg::dbg_status_t rx_debug
);

  // Running tally of assertion failures
  int fail_count = 0;

  // Reset clears lanes, flit and both status words
  reset_clear: assert property (@(posedge clk_wr)
    !rst_n |=> (tx_phy0 == '0) && (tx_phy1 == '0) && (rx_flit == '0) &&
               (tx_debug == '0) && (rx_debug == '0))
    else begin
      fail_count++;
      $error("lanes, flit or status words not cleared by reset");
    end

  // phy1 pad above the hi slice
  pad_zero: assert property (@(posedge clk_wr) disable iff (!rst_n)
    tx_phy1[78:68] == '0)
    else begin
      fail_count++;
      $error("phy1 pad bits 78:68 not zero");
    end

  // Online words carry last cycle's strobe and marker on both lanes
  lane_framing: assert property (@(posedge clk_wr) disable iff (!rst_n)
    tx_online_dly |=>
      (tx_phy0[0] == $past(auto_stb)) && (tx_phy1[0] == $past(auto_stb)) &&
      (tx_phy0[79] == $past(auto_mrk)) && (tx_phy1[79] == $past(auto_mrk)))
    else begin
      fail_count++;
      $error("strobe or marker on a sent lane word does not match the framing bits");
    end

  // Offline transmit idles both lanes
  offline_idle: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !tx_online_dly |=> (tx_phy0 == '0) && (tx_phy1 == '0))
    else begin
      fail_count++;
      $error("lanes active while transmit side offline");
    end

endmodule

bind lpif_phy_concat lpif_link_assert u_assert (
  .clk_wr        (clk_wr),
  .rst_n         (rst_n),
  .tx_online_dly (tx_online_dly),
  .auto_stb      (auto_stb),
  .auto_mrk      (auto_mrk),
  .tx_phy0       (tx_phy0),
  .tx_phy1       (tx_phy1),
  .rx_flit       (rx_flit),
  .tx_debug      (tx_debug),
  .rx_debug      (rx_debug)
);

//--- tests/lpif_link_tb.sv
// Random loopback testbench for the LPIF link master, checked against a cycle model.
// The transmit lanes feed the receive lanes directly.
`timescale 1ns/1ps

module lpif_link_tb;

  import lpif_pkg::*;

  localparam int period_ns         = 40;
  localparam int reset_cycles      = 8;
  localparam bit persistent_strobe = 1'b0;
  localparam bit persistent_marker = 1'b1;
  // Worst-case cycles per test, in run order
  localparam int test_cycles       = 6 + 36 + 40 + 30 + 44 + 10;
  localparam int margin_cycles     = 200;

  logic           clk_wr;
  logic           rst_n;
  logic           tx_online;
  logic           rx_online;
  logic [15:0]    delay_x_value;
  logic [15:0]    delay_y_value;
  logic           tx_mrk_userbit;
  logic           tx_stb_userbit;
  logic [79:0]    tx_phy0;
  logic [79:0]    tx_phy1;
  logic [3:0]     dstrm_state;
  logic [1:0]     dstrm_protid;
  logic [127:0]   dstrm_data;
  logic           dstrm_dvalid;
  logic [7:0]     dstrm_crc;
  logic           dstrm_crc_valid;
  logic           dstrm_valid;
  logic [3:0]     ustrm_state;
  logic [1:0]     ustrm_protid;
  logic [127:0]   ustrm_data;
  logic           ustrm_dvalid;
  logic [7:0]     ustrm_crc;
  logic           ustrm_crc_valid;
  logic           ustrm_valid;
  dbg_status_t    tx_downstream_debug_status;
  dbg_status_t    rx_upstream_debug_status;

  integer         seed = 32'hb16b85fb;
  int             errors = 0;
  int             checks = 0;

  ////////////////////
  // Model state
  ////////////////////

  // Consecutive high samples of each online input
  int             run_tx = 0;
  int             run_rx = 0;
  logic           m_tx_dly = 1'b0;
  logic           m_rx_dly = 1'b0;
  // Stage one is the flit on the lanes, stage two the upstream flit
  lpif_flit_u     lane_flit = '0;
  lpif_flit_u     m_rx_flit = '0;
  logic [79:0]    m_phy0 = '0;
  logic [79:0]    m_phy1 = '0;
  logic [17:0]    m_sent = '0;
  logic [17:0]    m_acc = '0;
  logic [11:0]    m_err = '0;

  tb_clock_gen #(
    .period_ns    (period_ns),
    .reset_cycles (reset_cycles)
  ) u_clock (
    .clk_wr (clk_wr),
    .rst_n  (rst_n)
  );

  // Lanes looped straight back
  lpif_link_master_top #(
    .PERSISTENT_STROBE (persistent_strobe),
    .PERSISTENT_MARKER (persistent_marker)
  ) dut (
    .clk_wr                     (clk_wr),
    .rst_n                      (rst_n),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .delay_x_value              (delay_x_value),
    .delay_y_value              (delay_y_value),
    .tx_mrk_userbit             (tx_mrk_userbit),
    .tx_stb_userbit             (tx_stb_userbit),
    .tx_phy0                    (tx_phy0),
    .rx_phy0                    (tx_phy0),
    .tx_phy1                    (tx_phy1),
    .rx_phy1                    (tx_phy1),
    .dstrm_state                (dstrm_state),
    .dstrm_protid               (dstrm_protid),
    .dstrm_data                 (dstrm_data),
    .dstrm_dvalid               (dstrm_dvalid),
    .dstrm_crc                  (dstrm_crc),
    .dstrm_crc_valid            (dstrm_crc_valid),
    .dstrm_valid                (dstrm_valid),
    .ustrm_state                (ustrm_state),
    .ustrm_protid               (ustrm_protid),
    .ustrm_data                 (ustrm_data),
    .ustrm_dvalid               (ustrm_dvalid),
    .ustrm_crc                  (ustrm_crc),
    .ustrm_crc_valid            (ustrm_crc_valid),
    .ustrm_valid                (ustrm_valid),
    .tx_downstream_debug_status (tx_downstream_debug_status),
    .rx_upstream_debug_status   (rx_upstream_debug_status)
  );

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_flit(input lpif_flit_u exp, input lpif_flit_u act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch at %0t: ustrm flit expected %h got %h", $time, exp, act);
    end
  endtask

  task automatic check_phy(input string name, input logic [phy_width-1:0] exp,
                           input logic [phy_width-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_debug(input string name, input dbg_status_t exp, input dbg_status_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  // One clock edge using inputs held since the last drive
  task automatic model_update();
    lpif_flit_u f;
    logic       stb;
    logic       mrk;
    stb = persistent_strobe ? 1'b1 : tx_stb_userbit;
    mrk = persistent_marker ? 1'b1 : tx_mrk_userbit;
    // Receiver sees the word now on the lanes
    if (m_rx_dly && m_phy0[0]) begin
      m_rx_flit = lane_flit;
      if (m_acc != '1) m_acc = m_acc + 18'd1;
    end else begin
      m_rx_flit = '0;
      if (m_rx_dly && (m_err != '1)) m_err = m_err + 12'd1;
    end
    f.fields.state     = dstrm_state;
    f.fields.protid    = dstrm_protid;
    f.fields.data      = dstrm_data;
    f.fields.dvalid    = dstrm_dvalid;
    f.fields.crc       = dstrm_crc;
    f.fields.crc_valid = dstrm_crc_valid;
    f.fields.valid     = dstrm_valid;
    if (m_tx_dly) begin
      lane_flit = f;
      m_phy0    = {mrk, f.lanes.lo, stb};
      m_phy1    = {mrk, 11'h000, f.lanes.hi, stb};
      if (m_sent != '1) m_sent = m_sent + 18'd1;
    end else begin
      lane_flit = '0;
      m_phy0    = '0;
      m_phy1    = '0;
    end
    // Flag rises once delay+1 highs came before this edge
    m_tx_dly = tx_online && (run_tx > int'(delay_x_value));
    m_rx_dly = rx_online && (run_rx > int'(delay_y_value));
    run_tx   = tx_online ? run_tx + 1 : 0;
    run_rx   = rx_online ? run_rx + 1 : 0;
  endtask

  // Model update on the edge and compare just after it
  task automatic step();
    lpif_flit_u  got;
    dbg_status_t exp_tx;
    dbg_status_t exp_rx;
    @(posedge clk_wr);
    model_update();
    #1;
    got.fields.state     = ustrm_state;
    got.fields.protid    = ustrm_protid;
    got.fields.data      = ustrm_data;
    got.fields.dvalid    = ustrm_dvalid;
    got.fields.crc       = ustrm_crc;
    got.fields.crc_valid = ustrm_crc_valid;
    got.fields.valid     = ustrm_valid;
    exp_tx = {12'h000, m_tx_dly, m_rx_dly, m_sent};
    exp_rx = {m_err, m_tx_dly, m_rx_dly, m_acc};
    check_flit(m_rx_flit, got);
    check_phy("tx_phy0", m_phy0, tx_phy0);
    check_phy("tx_phy1", m_phy1, tx_phy1);
    check_debug("tx_downstream_debug_status", exp_tx, tx_downstream_debug_status);
    check_debug("rx_upstream_debug_status", exp_rx, rx_upstream_debug_status);
    #1;
  endtask

  ////////////////////
  // Stimulus helpers
  ////////////////////

  task automatic drive_fields();
    dstrm_state     = 4'($random(seed));
    dstrm_protid    = 2'($random(seed));
    dstrm_data      = {$random(seed), $random(seed), $random(seed), $random(seed)};
    dstrm_dvalid    = 1'($random(seed));
    dstrm_crc       = 8'($random(seed));
    dstrm_crc_valid = 1'($random(seed));
    dstrm_valid     = 1'($random(seed));
    tx_mrk_userbit  = 1'($random(seed));
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    if (errors == errs_at_start) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: FAILED with %0d errors", name, errors - errs_at_start);
    end
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    int          mark;
    int          lead;
    int          waited;
    int          lows;
    logic [11:0] err_start;
    logic [17:0] sent_hold;
    tx_online       = 1'b0;
    rx_online       = 1'b0;
    delay_x_value   = '0;
    delay_y_value   = '0;
    tx_mrk_userbit  = 1'b0;
    tx_stb_userbit  = 1'b0;
    dstrm_state     = '0;
    dstrm_protid    = '0;
    dstrm_data      = '0;
    dstrm_dvalid    = 1'b0;
    dstrm_crc       = '0;
    dstrm_crc_valid = 1'b0;
    dstrm_valid     = 1'b0;
    wait (rst_n === 1'b1);

    // Both sides offline so everything stays zero
    mark = errors;
    repeat (6) begin
      step();
      drive_fields();
    end
    report_test("reset_values", mark);

    // Receive goes online first and transmit a few cycles later
    mark = errors;
    delay_x_value  = 16'({$random(seed)} % 21);
    delay_y_value  = 16'({$random(seed)} % 21);
    tx_stb_userbit = 1'b1;
    rx_online      = 1'b1;
    lead           = {$random(seed)} % 4;
    repeat (lead) begin
      step();
      drive_fields();
    end
    tx_online = 1'b1;
    waited    = 0;
    // DUT online flags in the transmit status word
    while (!(tx_downstream_debug_status[19] && tx_downstream_debug_status[18]) &&
           (waited < 30)) begin
      step();
      drive_fields();
      waited++;
    end
    if (!(tx_downstream_debug_status[19] && tx_downstream_debug_status[18])) begin
      errors++;
      $display("online flags did not rise within 30 cycles of going online");
    end
    repeat (3) begin
      step();
      drive_fields();
    end
    report_test("online_holdoff", mark);

    mark = errors;
    repeat (40) begin
      step();
      drive_fields();
    end
    report_test("loopback_data", mark);

    // Random strobe and marker user bits
    mark = errors;
    repeat (30) begin
      step();
      drive_fields();
      tx_stb_userbit = 1'($random(seed));
    end
    report_test("framing", mark);

    // Flush pending strobe state before taking the start count
    mark = errors;
    tx_stb_userbit = 1'b1;
    repeat (2) begin
      step();
      drive_fields();
    end
    err_start = rx_upstream_debug_status[31:20];
    lows      = 0;
    repeat (40) begin
      step();
      drive_fields();
      tx_stb_userbit = (($random(seed) & 3) != 0);
      if (!tx_stb_userbit) lows++;
    end
    tx_stb_userbit = 1'b1;
    repeat (2) begin
      step();
      drive_fields();
    end
    if (rx_upstream_debug_status[31:20] !== 12'(err_start + lows)) begin
      errors++;
      $display("strobe error count went from %0d to %0d, expected a rise of %0d",
               err_start, rx_upstream_debug_status[31:20], lows);
    end
    report_test("strobe_loss", mark);

    // Sent count must freeze once transmit drops
    mark = errors;
    tx_online = 1'b0;
    repeat (2) begin
      step();
      drive_fields();
    end
    sent_hold = tx_downstream_debug_status[17:0];
    repeat (8) begin
      step();
      drive_fields();
    end
    if (tx_downstream_debug_status[17:0] !== sent_hold) begin
      errors++;
      $display("sent-word count kept rising after tx_online dropped");
    end
    report_test("going_offline", mark);

    errors += dut.u_phy_concat.u_assert.fail_count;
    $display("tests: 6, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (reset_cycles + test_cycles + margin_cycles) @(posedge clk_wr);
    $display("watchdog timeout: run still going after %0d cycles",
             reset_cycles + test_cycles + margin_cycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- verilog.f
source/lpif_pkg.sv
source/ll_auto_sync.sv
source/lpif_flit_map.sv
source/lpif_phy_concat.sv
source/lpif_link_master_top.sv
tests/tb_clock_gen.sv
tests/lpif_link_assert.sv
tests/lpif_link_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the LPIF link testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module lpif_link_tb -f verilog.f -o lpif_link_sim

./obj_dir/lpif_link_sim +verilator+error+limit+100 | tee sim.log

if grep -q "^Simulation passed$" sim.log; then
  exit 0
else
  exit 1
fi
